// File: hdl/sprite_pkg.sv
//*********************************************************************
// 640x480 60 Hz geometry only; all coordinates fit in cordw bits
// spr_file is relative to the directory the simulator runs from
//*********************************************************************

package sprite_pkg;

    localparam int cordw = 10;              // coordinate width, covers h_total

    typedef logic [cordw-1:0] coord_t;      // unsigned screen coordinate

    // horizontal timing, in pixels
    localparam coord_t h_res  = 10'd640;    // active pixels
    localparam coord_t h_fp   = 10'd16;     // front porch
    localparam coord_t h_sync = 10'd96;     // sync pulse
    localparam coord_t h_bp   = 10'd48;     // back porch

    // vertical timing, in lines
    localparam coord_t v_res  = 10'd480;    // active lines
    localparam coord_t v_fp   = 10'd10;
    localparam coord_t v_sync = 10'd2;
    localparam coord_t v_bp   = 10'd33;

    localparam coord_t h_total = h_res + h_fp + h_sync + h_bp;  // 800
    localparam coord_t v_total = v_res + v_fp + v_sync + v_bp;  // 525

    // sync windows, end is exclusive
    localparam coord_t hs_beg = h_res + h_fp;
    localparam coord_t hs_end = hs_beg + h_sync;
    localparam coord_t vs_beg = v_res + v_fp;
    localparam coord_t vs_end = vs_beg + v_sync;

    // sprite bitmap, one hex byte per row, msb is the leftmost pixel
    localparam coord_t spr_w    = 10'd8;
    localparam coord_t spr_h    = 10'd8;
    localparam string  spr_file = "hdl/letter_f.mem";

    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;                                // 12-bit colour

    localparam rgb_t col_sprite = 12'hfc0;  // yellow
    localparam rgb_t col_back   = 12'h137;  // dark blue
    localparam rgb_t col_blank  = 12'h000;  // black in blanking

endpackage

// File: hdl/disp_if.sv
//*********************************************************************
// display timing bundle, one source and any number of sinks
// syncs are active low, line and frame are single-cycle strobes
//*********************************************************************

`timescale 1ns/1ps

interface disp_if;
    import sprite_pkg::*;

    coord_t sx;        // horizontal position
    coord_t sy;        // vertical position
    logic   hsync;     // active low
    logic   vsync;     // active low
    logic   de;        // in active area
    logic   line;      // sx == h_res, start of horizontal blanking
    logic   frame;     // sx == 0, sy == 0

    // driven by the timing generator
    modport src (
        output sx, sy, hsync, vsync, de, line, frame
    );

    // sprite engine and painter
    modport snk (
        input sx, sy, hsync, vsync, de, line, frame
    );

endinterface

// File: hdl/display_timing.sv
//*********************************************************************
// free-running 640x480 timing, every output registered
// first frame strobe comes on the first clock after reset release
//*********************************************************************

`timescale 1ns/1ps

module display_timing (
    input  logic clk_pix,
    input  logic rst_n,
    disp_if.src  disp
);
    import sprite_pkg::*;

    logic   run;    // low until the first clock after reset
    coord_t nx;     // next horizontal position
    coord_t ny;     // next vertical position
    logic   h_last; // sx at end of line
    logic   v_last; // sy at last line of frame

    assign h_last = (disp.sx == h_total - 1'b1);
    assign v_last = (disp.sy == v_total - 1'b1);

    // next position, held at 0,0 for the first clock so frame lines up
    always_comb begin
        nx = disp.sx;
        ny = disp.sy;
        if (run) begin
            if (h_last) begin
                nx = '0;
                ny = v_last ? '0 : disp.sy + 1'b1;  // vertical wrap
            end else begin
                nx = disp.sx + 1'b1;
            end
        end
    end

    // strobes decoded from the next position so they match sx, sy
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            run        <= 1'b0;
            disp.sx    <= '0;
            disp.sy    <= '0;
            disp.hsync <= 1'b1;   // idle high
            disp.vsync <= 1'b1;
            disp.de    <= 1'b0;
            disp.line  <= 1'b0;
            disp.frame <= 1'b0;
        end else begin
            run        <= 1'b1;
            disp.sx    <= nx;
            disp.sy    <= ny;
            disp.hsync <= !(nx >= hs_beg && nx < hs_end);
            disp.vsync <= !(ny >= vs_beg && ny < vs_end);
            disp.de    <= (nx < h_res) && (ny < v_res);
            disp.line  <= (nx == h_res);            // blanking starts
            disp.frame <= (nx == '0) && (ny == '0);
        end
    end

endmodule

// File: hdl/sprite_engine.sv
//*********************************************************************
// one 8x8 one-bit sprite, position sampled once per frame
// row for line 0 is fetched from the sprx/spry inputs before the latch
//*********************************************************************

`timescale 1ns/1ps

module sprite_engine (
    input  logic              clk_pix,
    input  logic              rst_n,
    disp_if.snk               disp,
    input  sprite_pkg::coord_t sprx,
    input  sprite_pkg::coord_t spry,
    output logic              pix,
    output logic              drawing
);
    import sprite_pkg::*;

    // bitmap, loaded at elaboration
    logic [spr_w-1:0] rom [spr_h];

    initial begin
        $readmemh(spr_file, rom);
    end

    coord_t spr_x;            // position for the current frame
    coord_t spr_y;

    logic [spr_w-1:0] line_buf;   // row for the line being drawn
    logic             row_ok;     // line_buf holds a sprite row

    // row fetch
    coord_t ny;               // line after the current one
    coord_t fetch_y;          // sprite top used for that line
    coord_t dy;               // row offset into the sprite
    logic   in_y;
    logic [$clog2(spr_h)-1:0] row;

    // pixel select
    coord_t cur_x;            // sprite left edge this cycle
    coord_t dx;               // column offset into the sprite
    logic   in_x;
    logic [$clog2(spr_w)-1:0] col;
    logic [spr_w-1:0] shifted;    // selected bit moved to msb

    always_comb begin
        ny = (disp.sy == v_total - 1'b1) ? '0 : disp.sy + 1'b1;
        // last line fetches row 0 of the coming frame, latch not yet taken
        fetch_y = (disp.sy == v_total - 1'b1) ? spry : spr_y;
        dy   = ny - fetch_y;
        in_y = (ny >= fetch_y) && (dy < spr_h);   // guard against mod wrap
        row  = dy[$clog2(spr_h)-1:0];
    end

    always_comb begin
        cur_x   = disp.frame ? sprx : spr_x;  // latch lands one cycle late
        dx      = disp.sx - cur_x;
        in_x    = (disp.sx >= cur_x) && (dx < spr_w);
        col     = dx[$clog2(spr_w)-1:0];
        shifted = line_buf << col;            // msb first
    end

    // per-frame position latch, no tearing on mid-frame moves
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            spr_x <= '0;
            spr_y <= '0;
        end else if (disp.frame) begin
            spr_x <= sprx;
            spr_y <= spry;
        end
    end

    // valid flag for the buffered row
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            row_ok <= 1'b0;
        end else if (disp.line) begin
            row_ok <= in_y;
        end
    end

    // line buffer, filled at start of horizontal blanking
    always_ff @(posedge clk_pix) begin
        if (disp.line) begin
            line_buf <= in_y ? rom[row] : '0;   // clear outside sprite
        end
    end

    // registered outputs, one cycle behind sx
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            drawing <= 1'b0;
            pix     <= 1'b0;
        end else begin
            drawing <= in_x && row_ok;
            pix     <= shifted[spr_w-1];      // bitmap bit at sx - sprx
        end
    end

endmodule

// File: hdl/pixel_painter.sv
//*********************************************************************
// colour select plus sync alignment, two cycles behind the timing
// generator in total; blanking forces black
//*********************************************************************

`timescale 1ns/1ps

module pixel_painter (
    input  logic              clk_pix,
    input  logic              rst_n,
    disp_if.snk               disp,
    input  logic              pix,
    input  logic              drawing,
    output logic              hsync,
    output logic              vsync,
    output logic              de,
    output sprite_pkg::rgb_t  rgb
);
    import sprite_pkg::*;

    logic hsync_d;  // syncs lined up with pix and drawing
    logic vsync_d;
    logic de_d;
    rgb_t paint;    // colour before blanking

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            hsync_d <= 1'b1;
            vsync_d <= 1'b1;
            de_d    <= 1'b0;
        end else begin
            hsync_d <= disp.hsync;
            vsync_d <= disp.vsync;
            de_d    <= disp.de;
        end
    end

    assign paint = (drawing && pix) ? col_sprite : col_back;

    // output stage
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            hsync <= 1'b1;
            vsync <= 1'b1;
            de    <= 1'b0;
            rgb   <= col_blank;
        end else begin
            hsync <= hsync_d;
            vsync <= vsync_d;
            de    <= de_d;
            rgb   <= de_d ? paint : col_blank;   // black in blanking
        end
    end

endmodule

// File: hdl/sprite_display_top.sv
//*********************************************************************
// sprite display core, no PLL and no output pads
// outputs lag the internal coordinates by two pixel clocks
//*********************************************************************

`timescale 1ns/1ps

module sprite_display_top (
    input  logic               clk_pix,   // pixel clock, 25.175 MHz nominal
    input  logic               rst_n,
    input  sprite_pkg::coord_t sprx,      // sprite left edge
    input  sprite_pkg::coord_t spry,      // sprite top edge
    output logic               hsync,     // active low
    output logic               vsync,     // active low
    output logic               de,
    output sprite_pkg::rgb_t   rgb
);

    disp_if disp ();      // timing bundle, one producer two sinks

    logic pix;            // sprite bitmap bit
    logic drawing;        // inside sprite rectangle

    display_timing u_timing (
        .clk_pix (clk_pix),
        .rst_n   (rst_n),
        .disp    (disp.src)
    );

    sprite_engine u_sprite (
        .clk_pix (clk_pix),
        .rst_n   (rst_n),
        .disp    (disp.snk),
        .sprx    (sprx),
        .spry    (spry),
        .pix     (pix),
        .drawing (drawing)
    );

    pixel_painter u_paint (
        .clk_pix (clk_pix),
        .rst_n   (rst_n),
        .disp    (disp.snk),
        .pix     (pix),
        .drawing (drawing),
        .hsync   (hsync),
        .vsync   (vsync),
        .de      (de),
        .rgb     (rgb)
    );

endmodule

// File: dv/tb_sprite_display.sv
//*********************************************************************
// testbench for the sprite display core; run from the project root
// so the bitmap file path resolves, outputs sampled on falling edges
//*********************************************************************

`timescale 1ns/1ps

module tb_sprite_display;
    import sprite_pkg::*;

    localparam int unsigned seed = 32'hed2d0864;
    localparam int frame_cycles  = int'(h_total) * int'(v_total);
    localparam int wait_limit    = 4 * frame_cycles;    // cycles per wait

    logic   clk_pix;
    logic   rst_n;
    coord_t sprx;
    coord_t spry;
    logic   hsync;
    logic   vsync;
    logic   de;
    rgb_t   rgb;

    logic [spr_w-1:0] ref_rom [spr_h];  // model copy of the bitmap

    // model state, owned by the monitor
    logic   mon_on;
    logic   in_frame;      // tracking a frame that started after vsync
    logic   vs_seen;
    logic   de_q;
    logic   hs_q;
    logic   vs_q;
    logic   hs_armed;      // one hsync fall seen, period check valid
    int     px_x;          // active pixel index in the line
    int     px_y;          // active line index in the frame
    int     frame_cnt;
    int     hs_low;
    int     vs_low;
    int     hs_gap;
    int     spr_pix;       // sprite coloured pixels seen so far
    coord_t drv_x;         // position currently on the inputs
    coord_t drv_y;
    coord_t frm_x;         // position the checked frame was drawn with
    coord_t frm_y;

    sprite_display_top dut_i (
        .clk_pix (clk_pix),
        .rst_n   (rst_n),
        .sprx    (sprx),
        .spry    (spry),
        .hsync   (hsync),
        .vsync   (vsync),
        .de      (de),
        .rgb     (rgb)
    );

    always #20 clk_pix = ~clk_pix;  // 40 ns period

    // expected colour at active pixel x,y with the sprite at px,py
    function automatic rgb_t expected_rgb(int x, int y, int px, int py);
        int dx;
        int dy;
        dx = x - px;
        dy = y - py;
        if (x < 0 || x >= int'(h_res) || y < 0 || y >= int'(v_res)) begin
            return col_blank;
        end
        if (dx >= 0 && dx < int'(spr_w) && dy >= 0 && dy < int'(spr_h)) begin
            if (ref_rom[dy][int'(spr_w) - 1 - dx]) begin
                return col_sprite;
            end
        end
        return col_back;
    endfunction

    // set bits in the leftmost ncols columns of the bitmap
    function automatic int visible_bits(int ncols);
        int n;
        n = 0;
        for (int r = 0; r < int'(spr_h); r++) begin
            for (int c = 0; c < ncols; c++) begin
                if (ref_rom[r][int'(spr_w) - 1 - c]) n++;
            end
        end
        return n;
    endfunction

    task automatic check_val(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
            $display("sim failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic stop_run(string why);
        $display("error: %s at %0t", why, $time);
        $display("sim failed");
        $fatal(1, "run aborted");
    endtask

    task automatic check_idle();
        check_val("hsync", hsync, 1'b1);
        check_val("vsync", vsync, 1'b1);
        check_val("de", de, 1'b0);
        check_val("rgb", rgb, col_blank);
    endtask

    task automatic wait_frame(int target);
        int n;
        n = 0;
        while (frame_cnt < target) begin
            @(posedge clk_pix);
            n++;
            if (n > wait_limit) stop_run($sformatf("no start of frame %0d", target));
        end
    endtask

    task automatic wait_line(int line);
        int n;
        n = 0;
        while (!(in_frame && px_y == line)) begin
            @(posedge clk_pix);
            n++;
            if (n > wait_limit) stop_run($sformatf("active line %0d never seen", line));
        end
    endtask

    // new position, driven just after a rising edge
    task automatic move_sprite(coord_t x, coord_t y);
        @(posedge clk_pix);
        #2;
        sprx  = x;
        spry  = y;
        drv_x = x;
        drv_y = y;
    endtask

    // monitor and compare, falling edge so outputs are settled
    always @(negedge clk_pix) begin
        if (mon_on) begin
            if (!de) check_val("rgb", rgb, col_blank);  // blanking is black

            hs_gap++;
            if (!hsync) hs_low++;
            if (hsync && !hs_q) begin
                check_val("hsync low cycles", hs_low, h_sync);
                hs_low = 0;
            end
            if (!hsync && hs_q) begin
                if (hs_armed) check_val("hsync period", hs_gap, h_total);
                hs_armed = 1'b1;
                hs_gap   = 0;
            end

            if (!vsync) begin
                vs_low++;
                vs_seen = 1'b1;
            end
            if (vsync && !vs_q) begin
                check_val("vsync low cycles", vs_low, int'(v_sync) * int'(h_total));
                vs_low = 0;
            end
            if (!vsync && vs_q && in_frame) begin
                check_val("active lines", px_y + 1, v_res);
                in_frame = 1'b0;
            end

            if (de) begin
                if (!de_q) begin
                    if (vs_seen) begin       // first active line of a frame
                        vs_seen  = 1'b0;
                        in_frame = 1'b1;
                        frame_cnt++;
                        px_y  = 0;
                        frm_x = drv_x;       // latched in the DUT long before
                        frm_y = drv_y;
                    end else begin
                        px_y++;
                    end
                    px_x = 0;
                end
                if (in_frame) begin
                    check_val("rgb", rgb, expected_rgb(px_x, px_y, frm_x, frm_y));
                    if (rgb == col_sprite) spr_pix++;
                end
                px_x++;
            end
            if (!de && de_q && in_frame) check_val("active pixels", px_x, h_res);
        end
        de_q = de;
        hs_q = hsync;
        vs_q = vsync;
    end

    initial begin
        int snap;
        int expect_edge;
        clk_pix   = 1'b0;
        rst_n     = 1'b0;
        sprx      = 10'd100;
        spry      = 10'd236;    // sprite spans line 240, where it moves
        drv_x     = 10'd100;
        drv_y     = 10'd236;
        frm_x     = '0;
        frm_y     = '0;
        mon_on    = 1'b0;
        in_frame  = 1'b0;
        vs_seen   = 1'b0;
        de_q      = 1'b0;
        hs_q      = 1'b1;
        vs_q      = 1'b1;
        hs_armed  = 1'b0;
        px_x      = 0;
        px_y      = 0;
        frame_cnt = 0;
        hs_low    = 0;
        vs_low    = 0;
        hs_gap    = 0;
        spr_pix   = 0;
        void'($urandom(seed));
        $readmemh(spr_file, ref_rom);

        for (int i = 0; i < 5; i++) begin   // reset held 5 cycles
            @(negedge clk_pix);
            check_idle();
        end
        @(posedge clk_pix);
        #2;
        rst_n = 1'b1;
        @(posedge clk_pix);                 // first cycle after release
        @(negedge clk_pix);
        check_idle();
        mon_on = 1'b1;

        // two full frames at a fixed position
        wait_frame(3);
        if (spr_pix == 0) stop_run("no sprite pixels drawn in two frames");

        // mid-frame move, rest of frame 3 keeps the old spot
        wait_line(240);
        move_sprite(coord_t'($urandom % (h_res - spr_w + 1)),
                    coord_t'($urandom % (v_res - spr_h + 1)));
        wait_frame(5);

        // right edge, only four columns visible
        wait_line(240);
        move_sprite(h_res - 10'd4, coord_t'($urandom % (v_res - spr_h + 1)));
        wait_frame(6);
        snap        = spr_pix;
        expect_edge = visible_bits(4);
        wait_frame(7);
        check_val("edge sprite pixels", spr_pix - snap, expect_edge);

        $display("sim passed");
        $finish;
    end

endmodule

// File: hdl/letter_f.mem
// sprite rows top to bottom, one hex byte each, msb is the leftmost pixel
FE
80
80
FC
80
80
80
00

// File: tb.f
hdl/sprite_pkg.sv
hdl/disp_if.sv
hdl/display_timing.sv
hdl/sprite_engine.sv
hdl/pixel_painter.sv
hdl/sprite_display_top.sv
dv/tb_sprite_display.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f tb.f --top-module tb_sprite_display -o tb_sim

out=$(./obj_dir/tb_sim 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "sim passed"; then
    exit 0
fi
exit 1
